/* sim.f */
+incdir+tb
logic/psram_pkg.sv
logic/byte_port.sv
logic/mem_arbiter.sv
logic/word_mem_ctrl.sv
logic/psram_subsys.sv
tb/tb_psram_subsys.sv

/* Makefile */
# Verilator flow for the two-port byte memory subsystem
# override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_psram_subsys
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= FAIL: see errors above
VFLAGS    ?= --timing -Wno-fatal
SOURCES   := $(wildcard logic/*.sv tb/*.sv tb/*.svh)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# fails when the log holds the fail message or the run itself errors out
sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb/psram_model.svh */
// reference model for the two-port byte memory testbench
// shadow covers only the simulated word range, upper address bits dropped
// reads may only target bytes already written, the array has no reset
`ifndef PSRAM_MODEL_SVH
`define PSRAM_MODEL_SVH

localparam int SHADOW_BYTES = 4 << WORD_AW;

logic	[7:0]	shadow [SHADOW_BYTES];	// byte view of the whole array
int				known0 [$];				// bytes written through port 0
int				known1 [$];
logic	[7:0]	exp_q0 [$];				// expected read bytes, issue order
logic	[7:0]	exp_q1 [$];

function automatic int byte_index(input logic [ADDR_W-1:0] addr);
	return int'(addr[WORD_AW+1:0]);
endfunction

// shadow updated at issue time, port order keeps it valid
function automatic void note_write(input int p, input logic [ADDR_W-1:0] addr,
	input logic [7:0] data);
	shadow[byte_index(addr)] = data;
	if (p == 0) known0.push_back(byte_index(addr));
	else known1.push_back(byte_index(addr));
endfunction

function automatic void note_read(input int p, input logic [ADDR_W-1:0] addr);
	if (p == 0) exp_q0.push_back(shadow[byte_index(addr)]);
	else exp_q1.push_back(shadow[byte_index(addr)]);
endfunction

function automatic int known_count(input int p);
	return (p == 0) ? known0.size() : known1.size();
endfunction

// random byte this port has written before
function automatic int pick_known(input int p);
	if (p == 0) return known0[$urandom_range(0, known0.size() - 1)];
	return known1[$urandom_range(0, known1.size() - 1)];
endfunction

function automatic int pending_reads(input int p);
	return (p == 0) ? exp_q0.size() : exp_q1.size();
endfunction

function automatic logic [7:0] pop_expected(input int p);
	if (p == 0) return exp_q0.pop_front();
	return exp_q1.pop_front();
endfunction

`endif

/* tb/tb_psram_subsys.sv */
`timescale 1ns/1ps
// testbench for the two-port byte memory subsystem
// random traffic from a fixed seed, checked against a shadow byte model
// clients are driven on the falling edge, outputs sampled there too
// run ends on a cycle limit derived from the test lengths

module tb_psram_subsys;
	import psram_pkg::*;
	`include "psram_model.svh"

	// ------------------------------
	// test sizes and limits
	// ------------------------------
	localparam int RESET_CYCLES = 16;
	localparam int RAND_CMDS    = 200;	// per port
	localparam int BP_CMDS      = 40;	// per port, back to back
	localparam int SHARE_BYTES  = 16;
	localparam int SHARE_GAP    = 20;
	localparam int TEST_CMDS    = 8 + 2*RAND_CMDS + 2*BP_CMDS + 2*SHARE_BYTES;
	localparam int IDLE_CYCLES  = RESET_CYCLES + INIT_CYCLES + SHARE_GAP + 5*(READ_LAT + 4);
	localparam int WORST_LAT    = READ_LAT + CMD_CREDITS + LANE_Q_DEPTH + 4;
	localparam int CYCLE_LIMIT  = 2 * (TEST_CMDS + IDLE_CYCLES) * WORST_LAT;
	localparam int BUSY_LIMIT   = 100;	// per command wait
	localparam int DRAIN_LIMIT  = 200;
	localparam logic [ADDR_W-1:0] LANE_ADDR   = 22'h2a_0100;	// word 64, upper bits set
	localparam logic [ADDR_W-1:0] SHARE_ADDR0 = 22'h10_07f0;
	localparam logic [ADDR_W-1:0] SHARE_ADDR1 = 22'h03_07f0;	// same low bits, other upper

	logic					clk;
	logic					n_reset;
	logic					rd [2];
	logic					wr [2];
	logic	[ADDR_W-1:0]	address [2];
	logic	[7:0]			wdata [2];
	logic					busy [2];
	logic	[7:0]			rdata [2];
	logic					rdata_en [2];

	string	test_name;
	int		errors;
	int		checks;
	int		tests;
	int		errs_at_start;
	int		cycles;
	int		pulses [2];		// rdata_en seen per port
	int		reads_issued [2];
	int		stalls [2];		// negedges spent waiting on busy

	psram_subsys i_psram_subsys (
		.clk(clk), .n_reset(n_reset),
		.rd_0(rd[0]), .wr_0(wr[0]), .address_0(address[0]), .wdata_0(wdata[0]),
		.busy_0(busy[0]), .rdata_0(rdata[0]), .rdata_en_0(rdata_en[0]),
		.rd_1(rd[1]), .wr_1(wr[1]), .address_1(address[1]), .wdata_1(wdata[1]),
		.busy_1(busy[1]), .rdata_1(rdata[1]), .rdata_en_1(rdata_en[1])
	);

	always #10 clk = ~clk;	// 20 ns period

	// cycle limit against a stuck busy or a lost read
	always @(posedge clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("run stopped after %0d cycles without finishing the tests", cycles);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	// ------------------------------
	// helpers
	// ------------------------------
	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("Error: %s expected %0h actual %0h", name, expected, actual);
		end
	endtask

	task automatic begin_test(input string name);
		test_name     = name;
		errs_at_start = errors;
	endtask

	task automatic end_test();
		tests++;
		$display("test %s finished, %0d errors", test_name, errors - errs_at_start);
	endtask

	// drop the strobes on the next falling edge
	task automatic idle_port(input int p);
		@(negedge clk);
		rd[p] = 1'b0;
		wr[p] = 1'b0;
	endtask

	// one-cycle strobe on the first falling edge with busy low
	task automatic issue(input int p, input bit is_wr, input logic [ADDR_W-1:0] addr,
		input logic [7:0] data);
		int waited;
		waited = 0;
		idle_port(p);
		while (busy[p]) begin
			stalls[p]++;
			waited++;
			if (waited > BUSY_LIMIT) begin
				errors++;
				$display("busy_%0d stuck high for %0d cycles in %s", p, waited, test_name);
				return;
			end
			@(negedge clk);
		end
		rd[p]      = !is_wr;
		wr[p]      = is_wr;
		address[p] = addr;
		wdata[p]   = data;
		if (is_wr) begin
			note_write(p, addr, data);
		end else begin
			note_read(p, addr);
			reads_issued[p]++;
		end
	endtask

	// reads only hit bytes this port wrote, each port in its own half
	task automatic random_traffic(input int p, input int n_cmds, input int read_pct,
		input bit gaps);
		logic	[ADDR_W-1:0]	addr;
		bit						do_rd;
		int						low;
		for (int i = 0; i < n_cmds; i++) begin
			if (gaps && $urandom_range(0, 3) == 0) idle_port(p);
			do_rd = known_count(p) != 0 && $urandom_range(0, 99) < read_pct;
			if (do_rd) low = pick_known(p);
			else low = (p << (WORD_AW + 1)) | $urandom_range(0, (2 << WORD_AW) - 1);
			addr = ADDR_W'($urandom);	// junk upper bits, dropped by the port
			addr[WORD_AW+1:0] = (WORD_AW+2)'(low);
			issue(p, !do_rd, addr, 8'($urandom));
		end
		idle_port(p);
	endtask

	// wait for every expected read, then a quiet tail for strays
	task automatic drain();
		int waited;
		waited = 0;
		while ((pending_reads(0) != 0 || pending_reads(1) != 0) && waited < DRAIN_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		if (pending_reads(0) != 0 || pending_reads(1) != 0) begin
			errors++;
			$display("reads never returned in %s: %0d on port 0, %0d on port 1",
				test_name, pending_reads(0), pending_reads(1));
		end
		repeat (READ_LAT + 4) @(negedge clk);
	endtask

	// ------------------------------
	// read return monitor
	// ------------------------------
	always @(negedge clk) begin
		if (n_reset) begin
			for (int p = 0; p < 2; p++) begin
				if (rdata_en[p]) begin
					pulses[p]++;
					if (pending_reads(p) == 0) begin
						errors++;
						$display("port %0d returned data with no read outstanding in %s",
							p, test_name);
					end else begin
						check_value($sformatf("%s port%0d rdata", test_name, p),
							32'(pop_expected(p)), 32'(rdata[p]));
					end
				end else begin
					check_value($sformatf("%s port%0d idle rdata", test_name, p),
						32'd0, 32'(rdata[p]));	// no data outside the pulse
				end
			end
		end
	end

	// ------------------------------
	// test sequence
	// ------------------------------
	initial begin
		int				high [2];
		int				bounce [2];
		bit				low_seen [2];
		int				en_seen;
		int				reads_before [2];
		int				pulses_before [2];
		logic	[7:0]	lane_val [4];
		void'($urandom(32'hc765_62b2));
		clk     = 1'b0;
		n_reset = 1'b0;
		errors  = 0;
		checks  = 0;
		tests   = 0;
		cycles  = 0;
		for (int p = 0; p < 2; p++) begin
			rd[p]           = 1'b0;
			wr[p]           = 1'b0;
			address[p]      = '0;
			wdata[p]        = '0;
			pulses[p]       = 0;
			reads_issued[p] = 0;
			stalls[p]       = 0;
			high[p]         = 0;
			bounce[p]       = 0;
			low_seen[p]     = 1'b0;
		end
		repeat (RESET_CYCLES) @(negedge clk);

		// busy high for the whole init period, then low for good
		begin_test("init");
		n_reset = 1'b1;
		en_seen = 0;
		repeat (INIT_CYCLES + 8) begin
			for (int p = 0; p < 2; p++) begin
				if (busy[p]) begin
					if (low_seen[p]) bounce[p]++;
					else high[p]++;
				end else begin
					low_seen[p] = 1'b1;
				end
				if (rdata_en[p]) en_seen++;
			end
			@(negedge clk);
		end
		for (int p = 0; p < 2; p++) begin
			check_value($sformatf("init busy_%0d high cycles", p), INIT_CYCLES, high[p]);
			if (bounce[p] != 0) begin
				errors++;
				$display("busy_%0d went high again after init", p);
			end
		end
		if (en_seen != 0) begin
			errors++;
			$display("rdata_en pulsed %0d times during init", en_seen);
		end
		end_test();

		// four lanes of one word, then read each back
		begin_test("lane_placement");
		lane_val = '{8'ha5, 8'h3c, 8'h5a, 8'hc3};
		for (int l = 0; l < 4; l++) issue(0, 1'b1, LANE_ADDR | ADDR_W'(l), lane_val[l]);
		for (int l = 0; l < 4; l++) issue(0, 1'b0, LANE_ADDR | ADDR_W'(l), 8'h00);
		idle_port(0);
		drain();
		end_test();

		begin_test("random_traffic");
		fork
			random_traffic(0, RAND_CMDS, 50, 1'b1);
			random_traffic(1, RAND_CMDS, 50, 1'b1);
		join
		drain();
		end_test();

		// no gaps, mostly reads, so credits and lane queue run out
		begin_test("back_pressure");
		for (int p = 0; p < 2; p++) begin
			reads_before[p]  = reads_issued[p];
			pulses_before[p] = pulses[p];
			stalls[p]        = 0;
		end
		fork
			random_traffic(0, BP_CMDS, 75, 1'b0);
			random_traffic(1, BP_CMDS, 75, 1'b0);
		join
		drain();
		for (int p = 0; p < 2; p++) begin
			check_value($sformatf("back_pressure port%0d rdata_en count", p),
				reads_issued[p] - reads_before[p], pulses[p] - pulses_before[p]);
			if (stalls[p] == 0) begin
				errors++;
				$display("busy_%0d never rose under back-to-back commands", p);
			end
		end
		end_test();

		// port 1 reads what port 0 wrote
		begin_test("sharing");
		for (int i = 0; i < SHARE_BYTES; i++) begin
			issue(0, 1'b1, SHARE_ADDR0 + ADDR_W'(i), 8'($urandom));
		end
		idle_port(0);
		repeat (SHARE_GAP) @(negedge clk);
		for (int i = 0; i < SHARE_BYTES; i++) issue(1, 1'b0, SHARE_ADDR1 + ADDR_W'(i), 8'h00);
		idle_port(1);
		drain();
		end_test();

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

/* logic/psram_subsys.sv */
`timescale 1ns/1ps
// two byte clients sharing one word memory through a round-robin arbiter
// everything on clk, no external memory pins
// busy high for INIT_CYCLES after reset and whenever a port is out of credits

module psram_subsys (
	input							clk,
	input							n_reset,
	input							rd_0,
	input							wr_0,
	input	[psram_pkg::ADDR_W-1:0]	address_0,
	input	[7:0]					wdata_0,
	output							busy_0,
	output	[7:0]					rdata_0,
	output							rdata_en_0,
	input							rd_1,
	input							wr_1,
	input	[psram_pkg::ADDR_W-1:0]	address_1,
	input	[7:0]					wdata_1,
	output							busy_1,
	output	[7:0]					rdata_1,
	output							rdata_en_1
);
	import psram_pkg::*;

	// port to arbiter
	logic					cmd_valid0, cmd_valid1;
	logic					cmd_wr0, cmd_wr1;
	logic	[WORD_AW-1:0]	cmd_addr0, cmd_addr1;
	mem_word_t				cmd_wdata0, cmd_wdata1;
	logic	[3:0]			cmd_mask0, cmd_mask1;
	logic					credit_ret0, credit_ret1;
	logic					port_rd_valid0, port_rd_valid1;
	mem_word_t				port_rd_word0, port_rd_word1;
	// arbiter to controller
	logic					ready;
	logic					mem_req, mem_wr, mem_tag;
	logic	[WORD_AW-1:0]	mem_addr;
	mem_word_t				mem_wdata;
	logic	[3:0]			mem_mask;
	logic					rd_valid, rd_tag;
	mem_word_t				rd_word;

	byte_port u_port0 (
		.clk(clk), .n_reset(n_reset),
		.rd(rd_0), .wr(wr_0), .address(address_0), .wdata(wdata_0),
		.busy(busy_0), .rdata(rdata_0), .rdata_en(rdata_en_0),
		.ready(ready),
		.cmd_valid(cmd_valid0), .cmd_wr(cmd_wr0), .cmd_addr(cmd_addr0),
		.cmd_wdata(cmd_wdata0), .cmd_mask(cmd_mask0),
		.credit_ret(credit_ret0),
		.rd_valid(port_rd_valid0), .rd_word(port_rd_word0)
	);

	byte_port u_port1 (
		.clk(clk), .n_reset(n_reset),
		.rd(rd_1), .wr(wr_1), .address(address_1), .wdata(wdata_1),
		.busy(busy_1), .rdata(rdata_1), .rdata_en(rdata_en_1),
		.ready(ready),
		.cmd_valid(cmd_valid1), .cmd_wr(cmd_wr1), .cmd_addr(cmd_addr1),
		.cmd_wdata(cmd_wdata1), .cmd_mask(cmd_mask1),
		.credit_ret(credit_ret1),
		.rd_valid(port_rd_valid1), .rd_word(port_rd_word1)
	);

	mem_arbiter u_arb (
		.clk(clk), .n_reset(n_reset),
		.cmd_valid0(cmd_valid0), .cmd_wr0(cmd_wr0), .cmd_addr0(cmd_addr0),
		.cmd_wdata0(cmd_wdata0), .cmd_mask0(cmd_mask0), .credit_ret0(credit_ret0),
		.cmd_valid1(cmd_valid1), .cmd_wr1(cmd_wr1), .cmd_addr1(cmd_addr1),
		.cmd_wdata1(cmd_wdata1), .cmd_mask1(cmd_mask1), .credit_ret1(credit_ret1),
		.ready(ready),
		.mem_req(mem_req), .mem_wr(mem_wr), .mem_addr(mem_addr),
		.mem_wdata(mem_wdata), .mem_mask(mem_mask), .mem_tag(mem_tag),
		.rd_valid(rd_valid), .rd_word(rd_word), .rd_tag(rd_tag),
		.rd_valid0(port_rd_valid0), .rd_word0(port_rd_word0),
		.rd_valid1(port_rd_valid1), .rd_word1(port_rd_word1)
	);

	word_mem_ctrl u_mem (
		.clk(clk), .n_reset(n_reset),
		.mem_req(mem_req), .mem_wr(mem_wr), .mem_addr(mem_addr),
		.mem_wdata(mem_wdata), .mem_mask(mem_mask), .mem_tag(mem_tag),
		.ready(ready),
		.rd_valid(rd_valid), .rd_word(rd_word), .rd_tag(rd_tag)
	);

endmodule

/* logic/word_mem_ctrl.sv */
`timescale 1ns/1ps
// behavioural stand-in for the vendor memory interface
// ready rises INIT_CYCLES cycles after reset release, no refresh or calibration
// write commits on the request cycle, read data after READ_LAT cycles
// one request per cycle, only 2**WORD_AW words, contents not reset

module word_mem_ctrl (
	input								clk,
	input								n_reset,
	input								mem_req,
	input								mem_wr,
	input	[psram_pkg::WORD_AW-1:0]	mem_addr,
	input	psram_pkg::mem_word_t		mem_wdata,
	input	[3:0]						mem_mask,
	input								mem_tag,
	output	logic						ready,
	output								rd_valid,
	output	psram_pkg::mem_word_t		rd_word,
	output								rd_tag
);
	import psram_pkg::*;

	logic	[31:0]			mem_array [2**WORD_AW];
	logic	[INIT_W-1:0]	init_cnt;
	logic	[READ_LAT-1:0]	pipe_valid;
	mem_word_t				pipe_word [READ_LAT];
	logic					pipe_tag  [READ_LAT];

	// ------------------------------
	// init period
	// ------------------------------
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			init_cnt <= '0;
			ready    <= 1'b0;
		end else if (!ready) begin
			if (init_cnt == INIT_W'(INIT_CYCLES - 1)) begin
				ready <= 1'b1;	// stays high until next reset
			end else begin
				init_cnt <= init_cnt + 1'b1;
			end
		end
	end

	// ------------------------------
	// masked write
	// ------------------------------
	always_ff @(posedge clk) begin
		if (mem_req && mem_wr) begin
			for (int i = 0; i < 4; i++) begin
				if (mem_mask[i]) mem_array[mem_addr][8*i +: 8] <= mem_wdata.lane[i];
			end
		end
	end

	// ------------------------------
	// read pipeline
	// ------------------------------
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			pipe_valid <= '0;
		end else begin
			pipe_valid <= {pipe_valid[READ_LAT-2:0], mem_req & ~mem_wr};
		end
	end

	// stage 0 samples the array, later stages only shift
	always_ff @(posedge clk) begin
		pipe_word[0].word <= mem_array[mem_addr];
		pipe_tag[0]       <= mem_tag;
		for (int s = 1; s < READ_LAT; s++) begin
			pipe_word[s] <= pipe_word[s-1];
			pipe_tag[s]  <= pipe_tag[s-1];
		end
	end

	assign rd_valid = pipe_valid[READ_LAT-1];
	assign rd_word  = pipe_word[READ_LAT-1];
	assign rd_tag   = pipe_tag[READ_LAT-1];

endmodule

/* logic/mem_arbiter.sv */
`timescale 1ns/1ps
// two-port round-robin arbiter in front of the word memory controller
// ports must hold a credit per command, queues are CMD_CREDITS deep and never overflow
// grant is combinational from the queue heads, issued only while ready is high

module mem_arbiter (
	input								clk,
	input								n_reset,
	input								cmd_valid0,
	input								cmd_wr0,
	input	[psram_pkg::WORD_AW-1:0]	cmd_addr0,
	input	psram_pkg::mem_word_t		cmd_wdata0,
	input	[3:0]						cmd_mask0,
	output								credit_ret0,
	input								cmd_valid1,
	input								cmd_wr1,
	input	[psram_pkg::WORD_AW-1:0]	cmd_addr1,
	input	psram_pkg::mem_word_t		cmd_wdata1,
	input	[3:0]						cmd_mask1,
	output								credit_ret1,
	input								ready,
	output	logic						mem_req,
	output	logic						mem_wr,
	output	logic [psram_pkg::WORD_AW-1:0]	mem_addr,
	output	psram_pkg::mem_word_t		mem_wdata,
	output	logic [3:0]					mem_mask,
	output	logic						mem_tag,
	input								rd_valid,
	input	psram_pkg::mem_word_t		rd_word,
	input								rd_tag,
	output								rd_valid0,
	output	psram_pkg::mem_word_t		rd_word0,
	output								rd_valid1,
	output	psram_pkg::mem_word_t		rd_word1
);
	import psram_pkg::*;

	logic					in_valid [2];
	logic					in_wr    [2];
	logic	[WORD_AW-1:0]	in_addr  [2];
	mem_word_t				in_wdata [2];
	logic	[3:0]			in_mask  [2];
	logic					q_wr    [2][CMD_CREDITS];
	logic	[WORD_AW-1:0]	q_addr  [2][CMD_CREDITS];
	mem_word_t				q_wdata [2][CMD_CREDITS];
	logic	[3:0]			q_mask  [2][CMD_CREDITS];
	logic	[Q_PTR_W-1:0]	wr_ptr [2];
	logic	[Q_PTR_W-1:0]	rd_ptr [2];
	logic	[CREDIT_W-1:0]	q_cnt  [2];
	logic					grant  [2];
	logic					rr_ptr;	// port preferred on a tie
	logic					sel;

	assign in_valid[0] = cmd_valid0;
	assign in_wr[0]    = cmd_wr0;
	assign in_addr[0]  = cmd_addr0;
	assign in_wdata[0] = cmd_wdata0;
	assign in_mask[0]  = cmd_mask0;
	assign in_valid[1] = cmd_valid1;
	assign in_wr[1]    = cmd_wr1;
	assign in_addr[1]  = cmd_addr1;
	assign in_wdata[1] = cmd_wdata1;
	assign in_mask[1]  = cmd_mask1;

	// ------------------------------
	// command queues
	// ------------------------------
	always_ff @(posedge clk) begin
		for (int p = 0; p < 2; p++) begin
			if (in_valid[p]) begin
				q_wr[p][wr_ptr[p]]    <= in_wr[p];
				q_addr[p][wr_ptr[p]]  <= in_addr[p];
				q_wdata[p][wr_ptr[p]] <= in_wdata[p];
				q_mask[p][wr_ptr[p]]  <= in_mask[p];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!n_reset) begin
			for (int p = 0; p < 2; p++) begin
				wr_ptr[p] <= '0;
				rd_ptr[p] <= '0;
				q_cnt[p]  <= '0;
			end
			rr_ptr <= 1'b0;
		end else begin
			for (int p = 0; p < 2; p++) begin
				if (in_valid[p]) wr_ptr[p] <= wr_ptr[p] + 1'b1;
				if (grant[p]) rd_ptr[p] <= rd_ptr[p] + 1'b1;	// pop on grant
				q_cnt[p] <= q_cnt[p] + CREDIT_W'(in_valid[p]) - CREDIT_W'(grant[p]);
			end
			if (grant[0]) rr_ptr <= 1'b1;	// move past the winner
			else if (grant[1]) rr_ptr <= 1'b0;
		end
	end

	// ------------------------------
	// round-robin grant
	// ------------------------------
	assign grant[0] = ready && q_cnt[0] != '0 && (q_cnt[1] == '0 || !rr_ptr);
	assign grant[1] = ready && q_cnt[1] != '0 && (q_cnt[0] == '0 || rr_ptr);
	assign sel      = grant[1];

	always_comb begin
		mem_req   = grant[0] | grant[1];
		mem_wr    = q_wr[sel][rd_ptr[sel]];
		mem_addr  = q_addr[sel][rd_ptr[sel]];
		mem_wdata = q_wdata[sel][rd_ptr[sel]];
		mem_mask  = q_mask[sel][rd_ptr[sel]];
		mem_tag   = sel;	// port id rides with the read
	end

	assign credit_ret0 = grant[0];	// slot freed this cycle
	assign credit_ret1 = grant[1];

	// read return steered by tag
	assign rd_valid0 = rd_valid & ~rd_tag;
	assign rd_valid1 = rd_valid & rd_tag;
	assign rd_word0  = rd_word;
	assign rd_word1  = rd_word;

endmodule

/* logic/byte_port.sv */
`timescale 1ns/1ps
// byte access to word command adapter, one per client
// rd/wr are one-cycle strobes, ignored while busy is high
// address bits above the word array are not forwarded
// reads complete in issue order, LANE_Q_DEPTH outstanding at most

module byte_port (
	input								clk,
	input								n_reset,
	input								rd,
	input								wr,
	input	[psram_pkg::ADDR_W-1:0]		address,
	input	[7:0]						wdata,
	output								busy,
	output	[7:0]						rdata,
	output								rdata_en,
	input								ready,
	output	logic						cmd_valid,
	output	logic						cmd_wr,
	output	logic [psram_pkg::WORD_AW-1:0]	cmd_addr,
	output	psram_pkg::mem_word_t		cmd_wdata,
	output	logic [3:0]					cmd_mask,
	input								credit_ret,
	input								rd_valid,
	input	psram_pkg::mem_word_t		rd_word
);
	import psram_pkg::*;

	logic	[CREDIT_W-1:0]		credits;
	logic	[1:0]				lane_q [LANE_Q_DEPTH];	// byte lane of each pending read
	logic	[LANE_PTR_W-1:0]	lane_wr_ptr;
	logic	[LANE_PTR_W-1:0]	lane_rd_ptr;
	logic	[LANE_PTR_W:0]		lane_cnt;
	logic						accept;
	logic						rd_accept;
	mem_word_t					placed;
	logic	[7:0]				rdata_q;
	logic						rdata_en_q;

	// ------------------------------
	// back-pressure
	// ------------------------------
	assign busy = !ready ||
		credits == '0 ||
		lane_cnt == (LANE_PTR_W+1)'(LANE_Q_DEPTH);	// lane queue full

	assign accept    = (rd | wr) & ~busy;
	assign rd_accept = rd & ~wr & ~busy;	// wr wins if both raised

	// wdata into its lane, other lanes zero
	always_comb begin
		placed = '0;
		placed.lane[address[1:0]] = wdata;
	end

	// ------------------------------
	// command register
	// ------------------------------
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			cmd_valid <= 1'b0;
		end else begin
			cmd_valid <= accept;	// one cycle after the strobe
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			cmd_wr    <= wr;
			cmd_addr  <= address[WORD_AW+1:2];	// word address
			cmd_wdata <= placed;
			cmd_mask  <= wr ? (4'b0001 << address[1:0]) : 4'b0000;	// read writes nothing
		end
	end

	// credits spent on accept, back on each grant
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			credits <= CREDIT_W'(CMD_CREDITS);
		end else begin
			credits <= credits + CREDIT_W'(credit_ret) - CREDIT_W'(accept);
		end
	end

	// ------------------------------
	// read lane queue and extraction
	// ------------------------------
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			lane_wr_ptr <= '0;
			lane_rd_ptr <= '0;
			lane_cnt    <= '0;
			rdata_en_q  <= 1'b0;
		end else begin
			if (rd_accept) lane_wr_ptr <= lane_wr_ptr + 1'b1;	// wraps at depth
			if (rd_valid) lane_rd_ptr <= lane_rd_ptr + 1'b1;
			lane_cnt   <= lane_cnt + (LANE_PTR_W+1)'(rd_accept) -
				(LANE_PTR_W+1)'(rd_valid);
			rdata_en_q <= rd_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_accept) lane_q[lane_wr_ptr] <= address[1:0];
		if (rd_valid) rdata_q <= rd_word.lane[lane_q[lane_rd_ptr]];	// oldest read first
	end

	assign rdata_en = rdata_en_q;
	assign rdata    = rdata_en_q ? rdata_q : 8'd0;	// zero outside the pulse

endmodule

/* logic/psram_pkg.sv */
// shared constants and the memory word type for the byte-access memory port block
// word array covers 2**WORD_AW words, higher client address bits are dropped
// credit counter width must hold CMD_CREDITS
package psram_pkg;

	// ------------------------------
	// client side
	// ------------------------------
	localparam int ADDR_W       = 22;	// byte address from the client
	localparam int LANE_Q_DEPTH = 4;	// outstanding reads per port
	localparam int LANE_PTR_W   = 2;	// index into the lane queue

	// ------------------------------
	// port to arbiter
	// ------------------------------
	localparam int CMD_CREDITS  = 2;	// slots per port in the arbiter queue
	localparam int CREDIT_W     = 2;	// 0..CMD_CREDITS
	localparam int Q_PTR_W      = 1;	// arbiter queue index

	// ------------------------------
	// memory controller
	// ------------------------------
	localparam int WORD_AW      = 10;	// 1024 words simulated
	localparam int READ_LAT     = 3;	// grant to rd_valid
	localparam int INIT_CYCLES  = 32;	// ready low this long after reset
	localparam int INIT_W       = 6;

	// one 32-bit word, seen whole by the array
	// and as four byte lanes by the ports, lane 0 in bits 7:0
	typedef union packed {
		logic [31:0]		word;
		logic [3:0][7:0]	lane;
	} mem_word_t;

endpackage
